// File: tlcs_alu_params.svh
// Sizing macros for the ALU block. Included by the package and by every
// module that sizes its datapath from them.
`ifndef TLCS_ALU_PARAMS_SVH
`define TLCS_ALU_PARAMS_SVH

// datapath width, long operands
`define TLCS_DW 32

// divider steps per operand width
`define TLCS_DIV_W_ITER 16
`define TLCS_DIV_B_ITER 8

`define TLCS_OP_W 5

`endif

// File: tlcs_alu_pkg.sv
// Operation, carry-source and operand width types shared by the ALU
// block. Referenced by scoped name from the modules.
`include "tlcs_alu_params.svh"

package tlcs_alu_pkg;

    typedef enum logic [`TLCS_OP_W-1:0] {
        ADD,
        SUB,    // op0 - op1 - carry
        AND,
        OR,
        XOR,
        CPL,    // low half only
        DAA,
        BAND,
        BOR,
        BXOR,
        BSET,
        SHL,    // one bit per operation
        SHR,
        MUL,
        MULS,
        DIV,
        DIVS,
        MIRR,
        BS1B
    } alu_op_e;

    typedef enum logic [2:0] {
        CIN,    // stored carry
        COM,    // inverted stored carry
        HI,
        ZF,     // stored zero flag
        SA,     // sign of op2 at the current width
        SH,     // op2 bit 0
        ZERO
    } carry_src_e;

    typedef enum logic [1:0] {
        W_BYTE,
        W_WORD,
        W_LONG
    } op_width_e;

endpackage

// File: alu_res_if.sv
// Next result and flags from the ALU to the flag register, with the
// strobe that stores them.
`timescale 1ns/100ps
`include "tlcs_alu_params.svh"

interface alu_res_if;

    logic [`TLCS_DW-1:0] nx_rslt;
    logic                nx_c;
    logic                nx_h;  // carry out of bit 3
    logic                nx_n;
    logic                nx_z;
    logic                nx_v;
    logic                load;  // qualified by cen in the register

    modport alu (
        output nx_rslt, nx_c, nx_h, nx_n, nx_z, nx_v, load
    );

    modport flags (
        input  nx_rslt, nx_c, nx_h, nx_n, nx_z, nx_v, load
    );

endinterface

// File: tlcs_div.sv
// Iterative restoring divider, 32/16 or 16/8, signed or unsigned. One
// step per cen cycle; quot and rem are valid while done is high.
`timescale 1ns/100ps
`include "tlcs_alu_params.svh"

module tlcs_div(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  logic                  start,
    input  logic                  word,      // 32/16 when set, else 16/8
    input  logic                  sign,
    input  logic [`TLCS_DW-1:0]   dividend,
    input  logic [`TLCS_DW/2-1:0] divisor,
    output logic [`TLCS_DW/2-1:0] quot,
    output logic [`TLCS_DW/2-1:0] rem,
    output logic                  busy,
    output logic                  done,
    output logic                  v
);

localparam int HW = `TLCS_DW/2;
localparam int CW = $clog2(`TLCS_DIV_W_ITER);

logic [CW-1:0]       cnt;
logic [HW-1:0]       r, q, dsr;     // partial remainder, shifter, divisor
logic                word_r, sign_r, neg_q, neg_r, ovf_r;
logic                dvd_s, dsr_s;
logic [`TLCS_DW-1:0] dvd_mag;
logic [HW-1:0]       dsr_mag, r_init, q_init;
logic [HW:0]         r_sh;
logic [HW-1:0]       r_nx, q_nx, lim;

assign dvd_s = sign & (word ? dividend[`TLCS_DW-1] : dividend[HW-1]);
assign dsr_s = sign & (word ? divisor[HW-1] : divisor[HW/2-1]);

// byte mode keeps the upper halves of the magnitudes at zero
always_comb begin
    if (word) begin
        dvd_mag = dvd_s ? -dividend : dividend;
        dsr_mag = dsr_s ? -divisor : divisor;
        r_init  = dvd_mag[`TLCS_DW-1:HW];
        q_init  = dvd_mag[HW-1:0];
    end else begin
        dvd_mag = {{HW{1'b0}}, dvd_s ? -dividend[HW-1:0] : dividend[HW-1:0]};
        dsr_mag = {{HW/2{1'b0}}, dsr_s ? -divisor[HW/2-1:0] : divisor[HW/2-1:0]};
        r_init  = {{HW/2{1'b0}}, dvd_mag[HW-1:HW/2]};
        q_init  = {dvd_mag[HW/2-1:0], {HW/2{1'b0}}};
    end
end

// one subtract-and-shift step
always_comb begin
    r_sh = {r, q[HW-1]};
    if (r_sh >= {1'b0, dsr}) begin
        r_nx = HW'(r_sh - {1'b0, dsr});
        q_nx = {q[HW-2:0], 1'b1};
    end else begin
        r_nx = r_sh[HW-1:0];
        q_nx = {q[HW-2:0], 1'b0};
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy <= 1'b0;
        cnt  <= '0;
    end else if (cen) begin
        if (start) begin
            busy <= 1'b1;
            cnt  <= word ? CW'(`TLCS_DIV_W_ITER-1) : CW'(`TLCS_DIV_B_ITER-1);
        end else if (busy) begin
            busy <= cnt != '0;
            cnt  <= cnt - 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (cen) begin
        if (start) begin
            r      <= r_init;
            q      <= q_init;
            dsr    <= dsr_mag;
            word_r <= word;
            sign_r <= sign;
            neg_q  <= dvd_s ^ dsr_s;
            neg_r  <= dvd_s;             // remainder follows the dividend
            ovf_r  <= r_init >= dsr_mag; // also catches a zero divisor
        end else if (busy) begin
            r <= r_nx;
            q <= q_nx;
        end
    end
end

assign done = busy & cen & (cnt == '0);
assign quot = neg_q ? -q_nx : q_nx;
assign rem  = neg_r ? -r_nx : r_nx;

// largest signed quotient magnitude is one more when negative
assign lim = word_r ? (HW'(1) << (HW-1)) : (HW'(1) << (HW/2-1));
assign v   = ovf_r | (sign_r & (neg_q ? q_nx > lim : q_nx >= lim));

// busy only ends through done
a_busy_ends_on_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> $past(done));

a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy);

endmodule

// File: tlcs_alu.sv
// Combinational ALU for byte, word and long operands. Drives the next
// result and flags on res; divisions go through the iterative divider.
`timescale 1ns/100ps
`include "tlcs_alu_params.svh"

module tlcs_alu(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic                     exec,
    input  logic [`TLCS_DW-1:0]      op0,      // destination
    input  logic [`TLCS_DW-1:0]      op1,      // source
    input  logic [`TLCS_DW-1:0]      op2,      // extra operand
    input  tlcs_alu_pkg::op_width_e  width,
    input  tlcs_alu_pkg::alu_op_e    alu_sel,
    input  tlcs_alu_pkg::carry_src_e carry_sel,
    input  logic                     cin,
    input  logic                     hin,
    input  logic                     nin,
    input  logic                     zin,
    output logic                     div_busy,
    alu_res_if.alu                   res
);

localparam int DW = `TLCS_DW;
localparam int HW = DW/2;

logic                    cx, bs, ws, sub, bsel;
logic                    is_div, div_start, div_done, div_v, div_word;
logic [HW-1:0]           div_quot, div_rem;
logic [DW-1:0]           bx, sum, rslt;
logic                    hc, c8, c16, c32, add_c, add_h, add_v;
logic [7:0]              daa;
logic signed [DW-1:0]    smul;
logic [3:0]              bs_idx;
logic                    c_o, h_o, v_o;
tlcs_alu_pkg::op_width_e wsel;

function automatic logic msb(input logic [DW-1:0] x, input tlcs_alu_pkg::op_width_e w);
    case (w)
        tlcs_alu_pkg::W_BYTE: msb = x[7];
        tlcs_alu_pkg::W_WORD: msb = x[15];
        default:              msb = x[DW-1];
    endcase
endfunction

assign bs        = width == tlcs_alu_pkg::W_BYTE;
assign ws        = width == tlcs_alu_pkg::W_WORD;
assign is_div    = alu_sel == tlcs_alu_pkg::DIV || alu_sel == tlcs_alu_pkg::DIVS;
assign div_start = exec & is_div & ~div_busy;
assign bsel      = op0[op1[3:0]];

tlcs_div u_div (
    .clk      ( clk                          ),
    .rst_n    ( rst_n                        ),
    .cen      ( cen                          ),
    .start    ( div_start                    ),
    .word     ( ~bs                          ),
    .sign     ( alu_sel == tlcs_alu_pkg::DIVS ),
    .dividend ( op0                          ),
    .divisor  ( op1[HW-1:0]                  ),
    .quot     ( div_quot                     ),
    .rem      ( div_rem                      ),
    .busy     ( div_busy                     ),
    .done     ( div_done                     ),
    .v        ( div_v                        )
);

// packing of the divider result is decided at start
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
        div_word <= 1'b0;
    else if (cen && div_start)
        div_word <= ~bs;
end

always_comb begin
    case (carry_sel)
        tlcs_alu_pkg::CIN:  cx = cin;
        tlcs_alu_pkg::COM:  cx = ~cin;
        tlcs_alu_pkg::HI:   cx = 1'b1;
        tlcs_alu_pkg::ZF:   cx = zin;
        tlcs_alu_pkg::SA:   cx = msb(op2, width);
        tlcs_alu_pkg::SH:   cx = op2[0];
        default:            cx = 1'b0;
    endcase
end

// nibble-chained adder, subtraction as op0 + ~op1 + ~cx
always_comb begin
    sub = alu_sel == tlcs_alu_pkg::SUB;
    bx  = sub ? ~op1 : op1;
    {hc,  sum[3:0]}   = {1'b0, op0[3:0]}   + {1'b0, bx[3:0]}   + {4'd0, sub ^ cx};
    {c8,  sum[7:4]}   = {1'b0, op0[7:4]}   + {1'b0, bx[7:4]}   + {4'd0, hc};
    {c16, sum[15:8]}  = {1'b0, op0[15:8]}  + {1'b0, bx[15:8]}  + {8'd0, c8};
    {c32, sum[31:16]} = {1'b0, op0[31:16]} + {1'b0, bx[31:16]} + {16'd0, c16};
    add_c = sub ^ (bs ? c8 : ws ? c16 : c32);   // borrow on subtract
    add_h = sub ^ hc;
    add_v = (msb(op0, width) == msb(bx, width)) && (msb(sum, width) != msb(op0, width));
end

// decimal correction of the low byte
always_comb begin
    daa = 8'h00;
    if (hin || op0[3:0] > 4'd9)
        daa[3:0] = 4'h6;
    if (cin || op0[7:0] > 8'h99)
        daa[7:4] = 4'h6;
end

assign smul = $signed(op0[HW-1:0]) * $signed(op1[HW-1:0]);

always_comb begin
    bs_idx = 4'd0;
    for (int i = 0; i < HW; i++) begin
        if (op0[i])
            bs_idx = 4'(i);   // highest set bit wins
    end
end

always_comb begin
    rslt = op0;
    c_o  = cin;
    h_o  = hin;
    v_o  = 1'b0;
    case (alu_sel)
        tlcs_alu_pkg::ADD, tlcs_alu_pkg::SUB: begin
            rslt = sum;
            c_o  = add_c;
            h_o  = add_h;
            v_o  = add_v;
        end
        tlcs_alu_pkg::AND:  rslt = op0 & op1;
        tlcs_alu_pkg::OR:   rslt = op0 | op1;
        tlcs_alu_pkg::XOR:  rslt = op0 ^ op1;
        tlcs_alu_pkg::CPL:  rslt[HW-1:0] = ~op0[HW-1:0];
        tlcs_alu_pkg::DAA: begin
            rslt[7:0] = nin ? op0[7:0] - daa : op0[7:0] + daa;
            c_o = cin | (op0[7:0] > 8'h99);
            h_o = nin ? hin & (op0[3:0] < 4'd6) : op0[3:0] > 4'd9;
        end
        tlcs_alu_pkg::BAND: begin
            rslt[op1[3:0]] = bsel & cx;
            c_o = bsel & cx;
        end
        tlcs_alu_pkg::BOR: begin
            rslt[op1[3:0]] = bsel | cx;
            c_o = bsel | cx;
        end
        tlcs_alu_pkg::BXOR: begin
            rslt[op1[3:0]] = bsel ^ cx;
            c_o = bsel ^ cx;
        end
        tlcs_alu_pkg::BSET: rslt[op1[3:0]] = cx;
        tlcs_alu_pkg::SHL: begin
            rslt = {op2[DW-2:0], cx};
            c_o  = msb(op2, width);
        end
        tlcs_alu_pkg::SHR: begin
            rslt = {cx, op2[DW-1:1]};
            if (bs)
                rslt[7] = cx;
            if (ws)
                rslt[15] = cx;
            c_o = op2[0];
        end
        tlcs_alu_pkg::MUL:  rslt = op0[HW-1:0] * op1[HW-1:0];
        tlcs_alu_pkg::MULS: rslt = smul;
        tlcs_alu_pkg::MIRR: rslt[HW-1:0] = {<<{op0[HW-1:0]}};
        tlcs_alu_pkg::BS1B: begin
            rslt = DW'(bs_idx);
            v_o  = ~|op0[HW-1:0];  // nothing set
        end
        default: ;
    endcase
    // divider finishing overrides whatever is selected now
    if (div_done) begin
        rslt = div_word ? {div_rem, div_quot}
                        : {{HW{1'b0}}, div_rem[7:0], div_quot[7:0]};
        c_o  = cin;
        h_o  = hin;
        v_o  = div_v;
    end
end

assign wsel = div_done ? (div_word ? tlcs_alu_pkg::W_LONG : tlcs_alu_pkg::W_WORD) : width;

always_comb begin
    if (alu_sel == tlcs_alu_pkg::BSET && !div_done)
        res.nx_z = ~bsel;
    else begin
        case (wsel)
            tlcs_alu_pkg::W_BYTE: res.nx_z = rslt[7:0] == '0;
            tlcs_alu_pkg::W_WORD: res.nx_z = rslt[15:0] == '0;
            default:              res.nx_z = rslt == '0;
        endcase
    end
end

assign res.nx_rslt = rslt;
assign res.nx_c    = c_o;
assign res.nx_h    = h_o;
assign res.nx_n    = msb(rslt, wsel);
assign res.nx_v    = v_o;
assign res.load    = div_done | (exec & ~div_busy & ~is_div);

// instruction sequencing must wait for the divider
a_exec_idle: assert property (@(posedge clk) disable iff (!rst_n)
    exec |-> !div_busy);

endmodule

// File: tlcs_flag_reg.sv
// Result and flag register. Stores the ALU outputs on load and feeds
// c, h, n and z back to the ALU for carry chains and DAA.
`timescale 1ns/100ps
`include "tlcs_alu_params.svh"

module tlcs_flag_reg(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    alu_res_if.flags            res,
    output logic [`TLCS_DW-1:0] rslt,
    output logic                c,
    output logic                h,
    output logic                n,
    output logic                z,
    output logic                v
);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rslt <= '0;
        c    <= 1'b0;
        h    <= 1'b0;
        n    <= 1'b0;
        z    <= 1'b0;
        v    <= 1'b0;
    end else if (cen && res.load) begin
        rslt <= res.nx_rslt;
        c    <= res.nx_c;     // next ADD with CIN continues from here
        h    <= res.nx_h;
        n    <= res.nx_n;
        z    <= res.nx_z;
        v    <= res.nx_v;
    end
end

// an unknown strobe would corrupt the whole register
a_load_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(res.load));

endmodule

// File: tlcs_alu_core.sv
// Top level of the ALU block: the ALU, its divider and the flag
// register, with the stored flags looped back as ALU inputs.
`timescale 1ns/100ps
`include "tlcs_alu_params.svh"

module tlcs_alu_core(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic [`TLCS_DW-1:0]      op0,
    input  logic [`TLCS_DW-1:0]      op1,
    input  logic [`TLCS_DW-1:0]      op2,
    input  tlcs_alu_pkg::op_width_e  width,
    input  tlcs_alu_pkg::alu_op_e    alu_sel,
    input  tlcs_alu_pkg::carry_src_e carry_sel,
    input  logic                     exec,     // one-cycle strobe
    output logic                     div_busy,
    output logic [`TLCS_DW-1:0]      rslt,
    output logic                     c,
    output logic                     h,
    output logic                     n,
    output logic                     z,
    output logic                     v
);

alu_res_if res_if();

tlcs_alu u_alu (
    .clk       ( clk          ),
    .rst_n     ( rst_n        ),
    .cen       ( cen          ),
    .exec      ( exec         ),
    .op0       ( op0          ),
    .op1       ( op1          ),
    .op2       ( op2          ),
    .width     ( width        ),
    .alu_sel   ( alu_sel      ),
    .carry_sel ( carry_sel    ),
    .cin       ( c            ),   // stored flags loop back
    .hin       ( h            ),
    .nin       ( n            ),
    .zin       ( z            ),
    .div_busy  ( div_busy     ),
    .res       ( res_if.alu   )
);

tlcs_flag_reg u_flag_reg (
    .clk   ( clk          ),
    .rst_n ( rst_n        ),
    .cen   ( cen          ),
    .res   ( res_if.flags ),
    .rslt  ( rslt         ),
    .c     ( c            ),
    .h     ( h            ),
    .n     ( n            ),
    .z     ( z            ),
    .v     ( v            )
);

endmodule

// File: tb_tlcs_alu_core.sv
// Self-checking testbench for the ALU block. A task-based reference model
// sets the expected result and flags, and assertions compare them with the DUT.
`timescale 1ns/100ps
`include "tlcs_alu_params.svh"

module tb_tlcs_alu_core;

logic clk, rst_n, cen, exec;
logic [`TLCS_DW-1:0] op0, op1, op2;
tlcs_alu_pkg::op_width_e  width;
tlcs_alu_pkg::alu_op_e    alu_sel;
tlcs_alu_pkg::carry_src_e carry_sel;
logic div_busy, c, h, n, z, v;
logic [`TLCS_DW-1:0] rslt;
logic [`TLCS_DW-1:0] exp_rslt, lo_sum;
logic exp_c, exp_h, exp_n, exp_z, exp_v;
integer seed = 32'h9d39;
integer cycles = 0;
integer busy_cnt = 0;
integer i, x, y;

tlcs_alu_core tlcs_alu_core_i (.*);

always #10 clk = ~clk;

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cen && div_busy)
        busy_cnt = busy_cnt + 1;   // divider steps actually taken
    if (cycles >= 4000) begin
        $display("Verification failed");
        $fatal(1, "timeout, run did not finish");
    end
end

task automatic report_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
endtask

function automatic int wbits(input tlcs_alu_pkg::op_width_e w);
    wbits = (w == tlcs_alu_pkg::W_BYTE) ? 8 : (w == tlcs_alu_pkg::W_WORD) ? 16 : 32;
endfunction

// expected result and flags of a single-cycle operation
task automatic model_op(input tlcs_alu_pkg::alu_op_e op, input tlcs_alu_pkg::op_width_e w,
                        input tlcs_alu_pkg::carry_src_e cs, input logic [31:0] a, b, xo);
    logic [31:0] r, m;
    logic [32:0] full;
    logic [7:0] corr;
    logic cx, c1, h1, v1, bit_o;
    int nb;
    nb = wbits(w);
    m = (nb == 32) ? 32'hffff_ffff : (32'h1 << nb) - 1;
    case (cs)
        tlcs_alu_pkg::CIN: cx = exp_c;
        tlcs_alu_pkg::COM: cx = ~exp_c;
        tlcs_alu_pkg::HI:  cx = 1'b1;
        tlcs_alu_pkg::ZF:  cx = exp_z;
        tlcs_alu_pkg::SA:  cx = xo[nb-1];
        tlcs_alu_pkg::SH:  cx = xo[0];
        default:           cx = 1'b0;
    endcase
    r = a;
    c1 = exp_c;
    h1 = exp_h;
    v1 = 1'b0;
    bit_o = a[b[3:0]];
    case (op)
        tlcs_alu_pkg::ADD: begin
            r = a + b + cx;
            full = {1'b0, a & m} + {1'b0, b & m} + cx;
            c1 = full[nb];
            h1 = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + cx) > 15;
            v1 = (a[nb-1] == b[nb-1]) && (r[nb-1] != a[nb-1]);
        end
        tlcs_alu_pkg::SUB: begin
            r = a - b - cx;
            c1 = {1'b0, a & m} < {1'b0, b & m} + cx;   // borrow
            h1 = {1'b0, a[3:0]} < {1'b0, b[3:0]} + cx;
            v1 = (a[nb-1] != b[nb-1]) && (r[nb-1] != a[nb-1]);
        end
        tlcs_alu_pkg::AND:  r = a & b;
        tlcs_alu_pkg::OR:   r = a | b;
        tlcs_alu_pkg::XOR:  r = a ^ b;
        tlcs_alu_pkg::CPL:  r = {a[31:16], ~a[15:0]};
        tlcs_alu_pkg::DAA: begin
            // correction is subtracted when the stored n is set
            corr = ((exp_h || a[3:0] > 9) ? 8'h06 : 8'h00)
                 + ((exp_c || a[7:0] > 8'h99) ? 8'h60 : 8'h00);
            r[7:0] = exp_n ? a[7:0] - corr : a[7:0] + corr;
            c1 = exp_c | (a[7:0] > 8'h99);
            h1 = exp_n ? exp_h & (a[3:0] < 6) : a[3:0] > 9;
        end
        tlcs_alu_pkg::BAND: begin
            r[b[3:0]] = bit_o & cx;
            c1 = bit_o & cx;
        end
        tlcs_alu_pkg::BOR: begin
            r[b[3:0]] = bit_o | cx;
            c1 = bit_o | cx;
        end
        tlcs_alu_pkg::BXOR: begin
            r[b[3:0]] = bit_o ^ cx;
            c1 = bit_o ^ cx;
        end
        tlcs_alu_pkg::BSET: r[b[3:0]] = cx;
        tlcs_alu_pkg::SHL: begin
            r = {xo[30:0], cx};
            c1 = xo[nb-1];
        end
        tlcs_alu_pkg::SHR: begin
            r = {cx, xo[31:1]};
            r[nb-1] = cx;
            c1 = xo[0];
        end
        tlcs_alu_pkg::MUL:  r = a[15:0] * b[15:0];
        tlcs_alu_pkg::MULS: r = $signed(a[15:0]) * $signed(b[15:0]);
        tlcs_alu_pkg::MIRR: begin
            for (int k = 0; k < 16; k++)
                r[k] = a[15-k];
        end
        tlcs_alu_pkg::BS1B: begin
            r = 0;
            for (int k = 0; k < 16; k++)
                if (a[k])
                    r = k;
            v1 = a[15:0] == 0;
        end
        default: ;
    endcase
    exp_rslt = r;
    exp_c = c1;
    exp_h = h1;
    exp_v = v1;
    exp_n = r[nb-1];
    exp_z = (op == tlcs_alu_pkg::BSET) ? ~bit_o : (r & m) == 0;
endtask

// quotient truncates toward zero and the remainder follows the dividend
task automatic model_div(input logic sgn, input logic byte_m, input logic [31:0] a, b);
    longint sd, ss, q, rm, qmax, qmin;
    if (byte_m) begin
        sd = sgn ? longint'($signed(a[15:0])) : longint'(a[15:0]);
        ss = sgn ? longint'($signed(b[7:0])) : longint'(b[7:0]);
        qmax = sgn ? 127 : 255;
    end else begin
        sd = sgn ? longint'($signed(a)) : longint'(a);
        ss = sgn ? longint'($signed(b[15:0])) : longint'(b[15:0]);
        qmax = sgn ? 32767 : 65535;
    end
    qmin = sgn ? -(qmax + 1) : 0;
    q = (ss == 0) ? 0 : sd / ss;
    rm = (ss == 0) ? 0 : sd % ss;
    exp_v = (ss == 0) || q > qmax || q < qmin;
    exp_rslt = byte_m ? {16'h0, rm[7:0], q[7:0]} : {rm[15:0], q[15:0]};
    exp_n = byte_m ? exp_rslt[15] : exp_rslt[31];
    exp_z = byte_m ? exp_rslt[15:0] == 0 : exp_rslt == 0;
endtask

task automatic do_op(input tlcs_alu_pkg::alu_op_e op, input tlcs_alu_pkg::op_width_e w,
                     input tlcs_alu_pkg::carry_src_e cs, input logic [31:0] a, b, xo);
    model_op(op, w, cs, a, b, xo);
    alu_sel = op;
    width = w;
    carry_sel = cs;
    op0 = a;
    op1 = b;
    op2 = xo;
    exec = 1'b1;
    @(posedge clk);
    #2 exec = 1'b0;
    @(posedge clk);
    #2;
endtask

task automatic do_div(input logic sgn, input logic byte_m, input logic [31:0] a, b);
    model_div(sgn, byte_m, a, b);
    alu_sel = sgn ? tlcs_alu_pkg::DIVS : tlcs_alu_pkg::DIV;
    width = byte_m ? tlcs_alu_pkg::W_BYTE : tlcs_alu_pkg::W_WORD;
    op0 = a;
    op1 = b;
    busy_cnt = 0;
    exec = 1'b1;
    @(posedge clk);
    #2 exec = 1'b0;
    op0 = $random(seed);   // operands were captured at start
    op1 = $random(seed);
    while (div_busy) begin
        cen = ($random(seed) & 3) != 0;
        @(posedge clk);
        #2;
    end
    cen = 1'b1;
    a_busy_len: assert (busy_cnt == (byte_m ? `TLCS_DIV_B_ITER : `TLCS_DIV_W_ITER))
        else report_error("div_busy length in cen cycles is wrong");
    @(posedge clk);
    #2;
endtask

a_single: assert property (@(posedge clk) disable iff (!rst_n)
    (exec && cen && alu_sel != tlcs_alu_pkg::DIV && alu_sel != tlcs_alu_pkg::DIVS)
    |=> (rslt == exp_rslt && c == exp_c && h == exp_h && n == exp_n && z == exp_z
         && v == exp_v))
    else report_error("result or flags wrong after exec");

a_divide: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(div_busy) |-> (v == exp_v && (exp_v || (rslt == exp_rslt && n == exp_n
                                                  && z == exp_z))))
    else report_error("divide result or overflow wrong");

initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cen = 1'b1;
    exec = 1'b0;
    op0 = 0;
    op1 = 0;
    op2 = 0;
    width = tlcs_alu_pkg::W_BYTE;
    alu_sel = tlcs_alu_pkg::ADD;
    carry_sel = tlcs_alu_pkg::ZERO;
    {exp_rslt, exp_c, exp_h, exp_n, exp_z, exp_v} = 0;
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;
    a_reset: assert (rslt == 0 && {c, h, n, z, v, div_busy} == 0)
        else report_error("state not cleared by reset");

    for (i = 0; i < 30; i++)
        do_op((i & 1) ? tlcs_alu_pkg::SUB : tlcs_alu_pkg::ADD, tlcs_alu_pkg::op_width_e'(i % 3),
              (i % 5 == 0) ? tlcs_alu_pkg::HI : (i % 5 < 3) ? tlcs_alu_pkg::CIN
                                                            : tlcs_alu_pkg::ZERO,
              $random(seed), $random(seed), 0);
    // 64-bit addition from two chained long adds
    do_op(tlcs_alu_pkg::ADD, tlcs_alu_pkg::W_LONG, tlcs_alu_pkg::ZERO, 32'hf000_0001,
          32'h1fff_ffff, 0);
    lo_sum = rslt;
    do_op(tlcs_alu_pkg::ADD, tlcs_alu_pkg::W_LONG, tlcs_alu_pkg::CIN, 32'h1, 32'h2, 0);
    a_chain: assert ({rslt, lo_sum} == 64'h1_f000_0001 + 64'h2_1fff_ffff)
        else report_error("64-bit chained add wrong");

    for (i = 0; i < 24; i++)
        do_op(tlcs_alu_pkg::alu_op_e'(2 + i % 9), tlcs_alu_pkg::op_width_e'(i % 3),
              (i & 1) ? tlcs_alu_pkg::HI : tlcs_alu_pkg::CIN, $random(seed), $random(seed), 0);
    for (i = 0; i < 5; i++) begin
        x = 10 + ($unsigned($random(seed)) % 30);
        y = 10 + ($unsigned($random(seed)) % 30);
        do_op(tlcs_alu_pkg::ADD, tlcs_alu_pkg::W_BYTE, tlcs_alu_pkg::ZERO,
              (x / 10) * 16 + x % 10, (y / 10) * 16 + y % 10, 0);
        do_op(tlcs_alu_pkg::DAA, tlcs_alu_pkg::W_BYTE, tlcs_alu_pkg::CIN, rslt, 0, 0);
        a_bcd: assert (rslt[7:0] == ((x + y) / 10) * 16 + (x + y) % 10)
            else report_error("DAA result is not the BCD sum");
    end

    for (i = 0; i < 12; i++)
        do_op((i & 1) ? tlcs_alu_pkg::SHR : tlcs_alu_pkg::SHL, tlcs_alu_pkg::op_width_e'(i % 3),
              (i & 2) ? tlcs_alu_pkg::SA : tlcs_alu_pkg::SH, 0, 0, $random(seed));
    for (i = 0; i < 6; i++) begin
        do_op(tlcs_alu_pkg::MIRR, tlcs_alu_pkg::W_WORD, tlcs_alu_pkg::ZERO, $random(seed), 0, 0);
        do_op(tlcs_alu_pkg::BS1B, tlcs_alu_pkg::W_WORD, tlcs_alu_pkg::ZERO,
              $random(seed) >> i, 0, 0);
        do_op(tlcs_alu_pkg::MUL, tlcs_alu_pkg::W_LONG, tlcs_alu_pkg::ZERO,
              $random(seed), $random(seed), 0);
        do_op(tlcs_alu_pkg::MULS, tlcs_alu_pkg::W_LONG, tlcs_alu_pkg::ZERO,
              $random(seed), $random(seed), 0);
    end
    do_op(tlcs_alu_pkg::BS1B, tlcs_alu_pkg::W_WORD, tlcs_alu_pkg::ZERO, 32'hffff_0000, 0, 0);

    for (i = 0; i < 16; i++)
        do_div(i[0], i[1], $random(seed) >> (i % 8), ($random(seed) | 1) >> (i % 3));
    do_div(1'b0, 1'b1, 32'h1234, 32'h0);
    do_div(1'b1, 1'b0, 32'h1234, 32'h0);

    // known state with c and v set, then an exec with cen low must leave it alone
    do_op(tlcs_alu_pkg::ADD, tlcs_alu_pkg::W_LONG, tlcs_alu_pkg::ZERO, 32'h8000_0000,
          32'h8000_0001, 0);
    cen = 1'b0;
    alu_sel = tlcs_alu_pkg::ADD;
    op0 = 32'h55;
    op1 = 32'h77;
    exec = 1'b1;
    @(posedge clk);
    #2 exec = 1'b0;
    cen = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    a_hold: assert (rslt == exp_rslt && {c, h, n, z, v} == {exp_c, exp_h, exp_n, exp_z, exp_v})
        else report_error("state changed without a stored exec");

    $display("Verification passed");
    $finish;
end

endmodule

// File: tlcs_alu.f
+incdir+.
tlcs_alu_pkg.sv
alu_res_if.sv
tlcs_div.sv
tlcs_alu.sv
tlcs_flag_reg.sv
tlcs_alu_core.sv
tb_tlcs_alu_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ALU testbench; exit status follows the simulation
verilator --binary --timing --assert -Wno-fatal --top-module tb_tlcs_alu_core \
    -f tlcs_alu.f -o tb_sim && ./obj_dir/tb_sim || exit 1
